//--- Makefile
TOP = tb_stream_merge

all: run

build:
	verilator --binary --timing --assert -j 0 -f src.f --top-module $(TOP) -o $(TOP)

run: build
	@out="$$(./obj_dir/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "all tests passed"

lint:
	verilator --lint-only --timing --assert -f src.f --top-module $(TOP)

clean:
	rm -rf obj_dir

.PHONY: all build run lint clean

//--- source/fifo_0r0w.sv
/* Zero-latency FIFO */

`timescale 1ns/1ps

module fifo_0r0w #(
    parameter type T     = logic [7:0], // Payload type
    parameter int  DEPTH = 8            // Entries, one stays unused
) (
    input  logic i_clk,
    input  logic i_rst_n,

    // Write side, lands in memory at next edge
    input  logic i_push,
    output logic o_full,
    input  T     i_wdata,

    // Read side, combinational from head
    input  logic i_pop,
    output logic o_empty,
    output T     o_rdata
);

    localparam int AWIDTH = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam logic [AWIDTH-1:0] LAST_IDX = AWIDTH'(DEPTH - 1);

    T mem [DEPTH];                        // Storage, no reset

    logic [AWIDTH-1:0] push_idx;          // Next slot to write
    logic [AWIDTH-1:0] pop_idx;           // Current head
    logic [AWIDTH-1:0] next_push_idx;
    logic [AWIDTH-1:0] next_pop_idx;
    logic              idx_equal;         // Buffer holds nothing in memory

    // Index increment with wrap at DEPTH
    always_comb begin
        if (push_idx == LAST_IDX) begin
            next_push_idx = '0;
        end else begin
            next_push_idx = push_idx + AWIDTH'(1);
        end

        if (pop_idx == LAST_IDX) begin
            next_pop_idx = '0;
        end else begin
            next_pop_idx = pop_idx + AWIDTH'(1);
        end
    end

    assign idx_equal = (push_idx == pop_idx);

    // Full when one more push would catch up with the head
    // A pop in the same cycle frees a slot
    assign o_full  = (next_push_idx == pop_idx) & ~i_pop;

    // Same-cycle push into an empty buffer counts as a word
    assign o_empty = idx_equal & ~i_push;

    // Read mux with forwarding of the incoming word
    always_comb begin
        if (idx_equal & i_push) begin
            o_rdata = i_wdata;            // Bypass memory
        end else begin
            o_rdata = mem[pop_idx];       // Normal head read
        end
    end

    // Index registers
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            push_idx <= '0;
            pop_idx  <= '0;
        end else begin
            if (i_push) begin
                push_idx <= next_push_idx;
            end
            if (i_pop) begin
                pop_idx <= next_pop_idx;   // Forwarded word is consumed here too
            end
        end
    end

    // Memory write kept in its own process for RAM inference
    always_ff @(posedge i_clk) begin
        if (i_push) begin
            mem[push_idx] <= i_wdata;
        end
    end

endmodule : fifo_0r0w

//--- source/merge_pkg.sv
/* Stream merge shared types */

package merge_pkg;

    // Payload widths
    localparam int SAMPLE_W = 24;         // Channel A sample
    localparam int CHAN_W   = 4;          // Channel B channel number
    localparam int CODE_W   = 8;          // Channel B event code
    localparam int WORD_W   = 32;         // Merged output word

    // FIFO depths, usable capacity is one less
    localparam int DEPTH_A  = 8;
    localparam int DEPTH_B  = 4;

    // Merged word layout
    localparam int   SRC_BIT    = 31;     // Source tag position
    localparam logic SRC_A      = 1'b0;   // Tag for channel A words
    localparam logic SRC_B      = 1'b1;   // Tag for channel B words
    localparam int   SAMPLE_LSB = 0;      // A word: sample in 23..0
    localparam int   CODE_LSB   = 0;      // B word: code in 7..0
    localparam int   CHAN_LSB   = 8;      // B word: chan in 11..8

    // Channel A payload
    typedef logic [SAMPLE_W-1:0] sample_t;

    // Channel B payload, chan sits above code
    typedef struct packed {
        logic [CHAN_W-1:0] chan;
        logic [CODE_W-1:0] code;
    } event_t;

    // Tagged output word
    typedef logic [WORD_W-1:0] word_t;

endpackage : merge_pkg

//--- source/rr_merge.sv
/* Round-robin two-channel merge */

`timescale 1ns/1ps

module rr_merge
    import merge_pkg::*;
(
    input  logic    i_clk,
    input  logic    i_rst_n,

    // Channel A head
    input  logic    i_empty_a,
    input  sample_t i_head_a,

    // Channel B head
    input  logic    i_empty_b,
    input  event_t  i_head_b,

    // Consumer side
    input  logic    i_pop,
    output logic    o_pop_a,          // Pop to FIFO A
    output logic    o_pop_b,          // Pop to FIFO B
    output logic    o_empty,
    output word_t   o_word
);

    logic  prio_b;                    // Priority bit, 0 favours A
    logic  sel_b;                     // Channel shown on the output
    logic  pop_any;                   // Consumer takes a word
    word_t word_a;
    word_t word_b;

    // Channel selection
    always_comb begin
        if (i_empty_a & ~i_empty_b) begin
            sel_b = 1'b1;             // Only B has data
        end else if (~i_empty_a & i_empty_b) begin
            sel_b = 1'b0;             // Only A has data
        end else if (~i_empty_a & ~i_empty_b) begin
            sel_b = prio_b;           // Contention, follow priority
        end else begin
            sel_b = 1'b0;             // Nothing to show
        end
    end

    assign o_empty = i_empty_a & i_empty_b;
    assign pop_any = i_pop & ~o_empty;

    // Steer the pop to the shown FIFO only
    assign o_pop_a = pop_any & ~sel_b;
    assign o_pop_b = pop_any & sel_b;

    // A word: sample zero-extended, tag in the top bit
    always_comb begin
        word_a                                = '0;
        word_a[SAMPLE_LSB +: SAMPLE_W]        = i_head_a;
        word_a[SRC_BIT]                       = SRC_A;
    end

    // B word: chan over code, rest zero
    always_comb begin
        word_b                                = '0;
        word_b[CODE_LSB +: CODE_W]            = i_head_b.code;
        word_b[CHAN_LSB +: CHAN_W]            = i_head_b.chan;
        word_b[SRC_BIT]                       = SRC_B;
    end

    assign o_word = sel_b ? word_b : word_a;

    // Priority moves away from the channel just popped
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            prio_b <= 1'b0;           // Start with A
        end else if (pop_any) begin
            prio_b <= ~sel_b;
        end
    end

endmodule : rr_merge

//--- source/stream_merge_top.sv
/* Two-channel stream merger */

`timescale 1ns/1ps

module stream_merge_top
    import merge_pkg::*;
(
    input  logic    i_clk,
    input  logic    i_rst_n,

    // Producer A, samples
    input  logic    i_push_a,
    input  sample_t i_sample,
    output logic    o_full_a,

    // Producer B, event records
    input  logic    i_push_b,
    input  event_t  i_event,
    output logic    o_full_b,

    // Consumer
    input  logic    i_pop,
    output logic    o_empty,
    output word_t   o_word
);

    // FIFO heads and pops between buffers and merger
    logic    empty_a;
    sample_t head_a;
    logic    pop_a;
    logic    empty_b;
    event_t  head_b;
    logic    pop_b;

    // Channel A buffer
    fifo_0r0w #(
        .T     (sample_t),
        .DEPTH (DEPTH_A)
    ) fifo_a (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_push  (i_push_a),
        .o_full  (o_full_a),
        .i_wdata (i_sample),
        .i_pop   (pop_a),
        .o_empty (empty_a),
        .o_rdata (head_a)
    );

    // Channel B buffer
    fifo_0r0w #(
        .T     (event_t),
        .DEPTH (DEPTH_B)
    ) fifo_b (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_push  (i_push_b),
        .o_full  (o_full_b),
        .i_wdata (i_event),
        .i_pop   (pop_b),
        .o_empty (empty_b),
        .o_rdata (head_b)
    );

    // Arbiter and word packing
    rr_merge merge0 (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .i_empty_a (empty_a),
        .i_head_a  (head_a),
        .i_empty_b (empty_b),
        .i_head_b  (head_b),
        .i_pop     (i_pop),
        .o_pop_a   (pop_a),
        .o_pop_b   (pop_b),
        .o_empty   (o_empty),
        .o_word    (o_word)
    );

endmodule : stream_merge_top

//--- src.f
source/merge_pkg.sv
source/fifo_0r0w.sv
source/rr_merge.sv
source/stream_merge_top.sv
verif/merge_props.sv
verif/tb_stream_merge.sv

//--- verif/merge_props.sv
/* FIFO protocol checks */

`timescale 1ns/1ps

module merge_props #(
    parameter int DEPTH  = 8,
    parameter int AWIDTH = (DEPTH > 1) ? $clog2(DEPTH) : 1
) (
    input logic              i_clk,
    input logic              i_rst_n,
    input logic              i_push,
    input logic              i_full,
    input logic              i_pop,
    input logic              i_empty,
    input logic [AWIDTH-1:0] i_push_idx,      // Write index of the FIFO
    input logic [AWIDTH-1:0] i_pop_idx        // Head index of the FIFO
);

    // Producer holds off while full
    push_not_full: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_push |-> !i_full)
        else $error("FIFO pushed while full");

    // Consumer only pops a word that exists
    pop_not_empty: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_pop |-> !i_empty)
        else $error("FIFO popped while empty");

    // Indices wrap before DEPTH
    idx_in_range: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (int'(i_push_idx) < DEPTH) && (int'(i_pop_idx) < DEPTH))
        else $error("FIFO index reached DEPTH");

    // Buffer comes out of reset empty
    empty_after_reset: assert property (@(posedge i_clk)
        !i_rst_n |=> i_empty)
        else $error("FIFO not empty in the cycle after reset");

endmodule : merge_props

bind fifo_0r0w merge_props #(
    .DEPTH (DEPTH)
) props0 (
    .i_clk      (i_clk),
    .i_rst_n    (i_rst_n),
    .i_push     (i_push),
    .i_full     (o_full),
    .i_pop      (i_pop),
    .i_empty    (o_empty),
    .i_push_idx (push_idx),
    .i_pop_idx  (pop_idx)
);

//--- verif/merge_stim.txt
// One cycle per line, 11 hex digits: test id, ctrl, sample (6), event (3: chan, code)
// ctrl bits: 8 random data, 4 push A, 2 push B, 1 pop
460A00011A1
460A00022B2
460A00033C3
41000000000
41000000000
41000000000
41000000000
41000000000
41000000000
2500A5A5000
20000000000
230000005E7
20000000000
34111111000
34222222000
34333333000
34FEDCBA000
31000000000
31000000000
31000000000
31000000000
52000000101
52000000202
520000003FF
52000000404
51000000000
51000000000
51000000000
6E000000000
6F000000000
6D000000000
6B000000000
6E000000000
69000000000
6F000000000
6C000000000
69000000000
69000000000

//--- verif/tb_stream_merge.sv
/* Stream merger testbench */

`timescale 1ns/1ps

module tb_stream_merge
    import merge_pkg::*;
();

    localparam int          CLK_PERIOD = 4;
    localparam int          RST_CYCLES = 10;
    localparam int          NUM_VEC    = 38;          // Lines in the stimulus file
    localparam int          TIMEOUT_NS = (RST_CYCLES + NUM_VEC + 50) * CLK_PERIOD;
    localparam logic [31:0] SEED       = 32'h8316;

    // DUT ports
    logic    i_clk = 1'b0;
    logic    i_rst_n;
    logic    i_push_a;
    sample_t i_sample;
    logic    o_full_a;
    logic    i_push_b;
    event_t  i_event;
    logic    o_full_b;
    logic    i_pop;
    logic    o_empty;
    word_t   o_word;

    // Vector holds test id, ctrl, sample and event
    logic [43:0] stim [NUM_VEC];

    // Reference model state
    sample_t     qa [$];                  // Channel A contents
    event_t      qb [$];                  // Channel B contents
    logic        prio_b;                  // Model priority with 0 favouring A
    logic [31:0] lcg_state;

    // What was driven this cycle
    logic [3:0]  cur_test;
    logic        cur_push_a;
    logic        cur_push_b;
    logic        cur_pop;
    sample_t     cur_sample;
    event_t      cur_event;

    int word_errors = 0;
    int flag_errors = 0;
    int pops_seen   = 0;

    stream_merge_top dut0 (
        .i_clk    (i_clk),
        .i_rst_n  (i_rst_n),
        .i_push_a (i_push_a),
        .i_sample (i_sample),
        .o_full_a (o_full_a),
        .i_push_b (i_push_b),
        .i_event  (i_event),
        .o_full_b (o_full_b),
        .i_pop    (i_pop),
        .o_empty  (o_empty),
        .o_word   (o_word)
    );

    always #(CLK_PERIOD / 2) i_clk = ~i_clk;

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // Tag 0 with the sample in the low 24 bits
    function automatic word_t pack_a(input sample_t s);
        return {SRC_A, 7'b0, s};
    endfunction

    // Tag 1 with chan above code
    function automatic word_t pack_b(input event_t e);
        return {SRC_B, 19'b0, e.chan, e.code};
    endfunction

    function automatic string test_name(input logic [3:0] id);
        case (id)
            4'd1:    return "reset";
            4'd2:    return "forward";
            4'd3:    return "order";
            4'd4:    return "alternate";
            4'd5:    return "fill";
            4'd6:    return "random";
            default: return "unknown";
        endcase
    endfunction

    task automatic report_mismatch(input string what, input logic [31:0] exp_val,
                                   input logic [31:0] act_val);
        $display("CHECK FAILED %s: %s expected %h actual %h",
                 test_name(cur_test), what, exp_val, act_val);
    endtask

    task automatic check_reset_state();
        cur_test = 4'd1;
        assert (o_empty == 1'b1) else begin
            report_mismatch("o_empty", 32'd1, 32'(o_empty));
            flag_errors++;
        end
        assert (o_full_a == 1'b0) else begin
            report_mismatch("o_full_a", 32'd0, 32'(o_full_a));
            flag_errors++;
        end
        assert (o_full_b == 1'b0) else begin
            report_mismatch("o_full_b", 32'd0, 32'(o_full_b));
            flag_errors++;
        end
    endtask

    // Decode one line and drive what the model allows
    task automatic apply_vector(input logic [43:0] vec);
        logic [3:0] ctrl;
        sample_t    s;
        event_t     e;
        logic       want_a;
        logic       want_b;
        logic       want_pop;
        cur_test = vec[43:40];
        ctrl     = vec[39:36];
        s        = vec[35:12];
        e        = vec[11:0];
        if (ctrl[3]) begin                // Data comes from the LCG
            lcg_state = lcg_next(lcg_state);
            s         = lcg_state[27:4];
            lcg_state = lcg_next(lcg_state);
            e         = lcg_state[19:8];
        end
        want_a   = ctrl[2] && (qa.size() < DEPTH_A - 1);
        want_b   = ctrl[1] && (qb.size() < DEPTH_B - 1);
        want_pop = ctrl[0] && (want_a || want_b || (qa.size() != 0) || (qb.size() != 0));
        i_push_a <= want_a;
        i_sample <= s;
        i_push_b <= want_b;
        i_event  <= e;
        i_pop    <= want_pop;
        cur_push_a = want_a;
        cur_push_b = want_b;
        cur_pop    = want_pop;
        cur_sample = s;
        cur_event  = e;
    endtask

    // Compare DUT outputs with the model and retire the cycle
    task automatic check_and_advance();
        int    cnt_a;
        int    cnt_b;
        logic  sel_b;
        logic  exp_empty;
        logic  exp_full_a;
        logic  exp_full_b;
        word_t exp_word;
        cnt_a = qa.size();                // Counts before this cycle's pushes
        cnt_b = qb.size();
        if (cur_push_a) begin
            qa.push_back(cur_sample);     // Visible at once when forwarded
        end
        if (cur_push_b) begin
            qb.push_back(cur_event);
        end
        exp_empty  = (qa.size() == 0) && (qb.size() == 0);
        sel_b      = (qb.size() != 0) && ((qa.size() == 0) || prio_b);
        exp_full_a = (cnt_a == DEPTH_A - 1) && !(cur_pop && !sel_b);
        exp_full_b = (cnt_b == DEPTH_B - 1) && !(cur_pop && sel_b);
        exp_word   = '0;
        if (sel_b) begin
            exp_word = pack_b(qb[0]);
        end else if (qa.size() != 0) begin
            exp_word = pack_a(qa[0]);
        end

        assert (o_empty == exp_empty) else begin
            report_mismatch("o_empty", 32'(exp_empty), 32'(o_empty));
            flag_errors++;
        end
        assert (o_full_a == exp_full_a) else begin
            report_mismatch("o_full_a", 32'(exp_full_a), 32'(o_full_a));
            flag_errors++;
        end
        assert (o_full_b == exp_full_b) else begin
            report_mismatch("o_full_b", 32'(exp_full_b), 32'(o_full_b));
            flag_errors++;
        end
        if (!exp_empty) begin
            assert (o_word == exp_word) else begin
                report_mismatch("o_word", exp_word, o_word);
                word_errors++;
            end
        end

        if (cur_pop) begin
            pops_seen++;
            if (sel_b) begin
                qb.delete(0);
            end else begin
                qa.delete(0);
            end
            prio_b = !sel_b;              // Turn passes to the other channel
        end
    endtask

    // Watchdog
    initial begin
        #(TIMEOUT_NS);
        $display("Timeout: run did not finish within %0d ns", TIMEOUT_NS);
        $display("tests failed");
        $finish;
    end

    initial begin
        for (int i = 0; i < NUM_VEC; i++) begin
            stim[i] = ~44'(i);            // Address-dependent filler for lines the file misses
        end
        $readmemh("verif/merge_stim.txt", stim);
        lcg_state  = SEED;
        prio_b     = 1'b0;
        cur_test   = 4'd1;
        cur_push_a = 1'b0;
        cur_push_b = 1'b0;
        cur_pop    = 1'b0;
        cur_sample = '0;
        cur_event  = '0;

        i_rst_n  <= 1'b0;
        i_push_a <= 1'b0;
        i_sample <= '0;
        i_push_b <= 1'b0;
        i_event  <= '0;
        i_pop    <= 1'b0;
        repeat (RST_CYCLES) @(posedge i_clk);
        i_rst_n <= 1'b1;
        @(negedge i_clk);
        check_reset_state();

        if (stim[NUM_VEC-1] == ~44'(NUM_VEC - 1)) begin
            $display("Stimulus file verif/merge_stim.txt is missing or too short");
            flag_errors++;
        end

        for (int n = 0; n < NUM_VEC; n++) begin
            @(posedge i_clk);
            apply_vector(stim[n]);
            @(negedge i_clk);             // Outputs settled mid-cycle
            check_and_advance();
        end

        @(posedge i_clk);
        i_push_a <= 1'b0;
        i_push_b <= 1'b0;
        i_pop    <= 1'b0;
        @(negedge i_clk);

        $display("Pops %0d, word errors %0d, flag errors %0d",
                 pops_seen, word_errors, flag_errors);
        if (word_errors + flag_errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule : tb_stream_merge
